// File: logic/axi_bus_pkg.sv
package axi_bus_pkg;

  // ------------------------------------------------------------
  // field widths of the monitored AXI manager port
  // ------------------------------------------------------------

  // burst length field, beats minus one
  localparam int axi_len_w = 8;

  // burst size field, log2 of the bytes per beat
  localparam int axi_size_w = 3;

  // ------------------------------------------------------------
  // response codes
  // ------------------------------------------------------------

  // anything other than okay is counted as an error by the monitor
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_exokay = 2'b01,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } axi_resp_t;

endpackage

// File: logic/stat_map_pkg.sv
package stat_map_pkg;

  // ------------------------------------------------------------
  // widths
  // ------------------------------------------------------------

  // width of the register address on the read port
  localparam int reg_addr_w = 5;

  // width of the outstanding burst counters and their maxima
  localparam int depth_w = 8;

  // number of implemented statistic registers
  localparam int num_stats = 17;

  // ------------------------------------------------------------
  // register map
  // ------------------------------------------------------------

  // write side first, then the read side
  typedef enum logic [reg_addr_w-1:0] {
    stat_aw_burst_cnt  = 5'd0,
    stat_aw_depth_max  = 5'd1,
    stat_aw_len_min    = 5'd2,
    stat_aw_len_max    = 5'd3,
    stat_aw_bytes_sum  = 5'd4,
    stat_w_burst_cnt   = 5'd5,
    stat_w_depth_max   = 5'd6,
    stat_w_beat_cnt    = 5'd7,
    stat_w_err_cnt     = 5'd8,
    stat_ar_burst_cnt  = 5'd9,
    stat_ar_depth_max  = 5'd10,
    stat_ar_len_min    = 5'd11,
    stat_ar_len_max    = 5'd12,
    stat_ar_bytes_sum  = 5'd13,
    stat_r_burst_cnt   = 5'd14,
    stat_r_beat_cnt    = 5'd15,
    stat_r_err_cnt     = 5'd16
  } stat_id_t;

endpackage

// File: logic/burst_stats.sv
`timescale 1ns/1ps

module burst_stats
  import axi_bus_pkg::*;
#(
  parameter int stat_width = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  clear,
  input  logic                  fire,
  input  logic [axi_len_w-1:0]  len,
  input  logic [axi_size_w-1:0] size,
  output logic [stat_width-1:0] burst_cnt,
  output logic [stat_width-1:0] bytes_sum,
  output logic [axi_len_w-1:0]  len_min,
  output logic [axi_len_w-1:0]  len_max
);

  logic [stat_width-1:0] burst_bytes;

  // ------------------------------------------------------------
  // bytes requested by one burst
  // ------------------------------------------------------------

  // len+1 beats, each of 2**size bytes
  assign burst_bytes = (stat_width'(len) + stat_width'(1)) << size;

  // ------------------------------------------------------------
  // burst count and byte sum
  // ------------------------------------------------------------

  // both wrap at stat_width, which is what software expects
  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      burst_cnt <= '0;
      bytes_sum <= '0;
    end else if (fire) begin
      burst_cnt <= burst_cnt + stat_width'(1);
      bytes_sum <= bytes_sum + burst_bytes;
    end
  end

  // ------------------------------------------------------------
  // length minimum and maximum
  // ------------------------------------------------------------

  // the minimum starts at the largest length so the first burst replaces it
  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      len_min <= '1;
    end else if (fire && (len < len_min)) begin
      len_min <= len;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      len_max <= '0;
    end else if (fire && (len > len_max)) begin
      len_max <= len;
    end
  end

endmodule

// File: logic/depth_tracker.sv
`timescale 1ns/1ps

module depth_tracker
  import stat_map_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               clear,
  input  logic               inc,
  input  logic               dec,
  output logic [depth_w-1:0] depth,
  output logic [depth_w-1:0] depth_max
);

  // an accept and a completion in the same cycle cancel out
  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      depth <= '0;
    end else begin
      case ({inc, dec})
        2'b10: depth <= depth + depth_w'(1);
        2'b01: depth <= depth - depth_w'(1);
        default: depth <= depth;
      endcase
    end
  end

  // the maximum looks at the registered depth, so it trails an
  // accept by one more cycle than the depth itself
  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      depth_max <= '0;
    end else if (depth > depth_max) begin
      depth_max <= depth;
    end
  end

endmodule

// File: logic/xfer_stats.sv
`timescale 1ns/1ps

module xfer_stats #(
  parameter int stat_width = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  clear,
  input  logic                  beat,
  input  logic                  last,
  input  logic                  err,
  output logic [stat_width-1:0] beat_cnt,
  output logic [stat_width-1:0] burst_cnt,
  output logic [stat_width-1:0] err_cnt
);

  logic last_beat;

  // last only means something on an accepted beat
  assign last_beat = beat && last;

  // ------------------------------------------------------------
  // beat and burst counters
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      beat_cnt <= '0;
    end else if (beat) begin
      beat_cnt <= beat_cnt + stat_width'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      burst_cnt <= '0;
    end else if (last_beat) begin
      burst_cnt <= burst_cnt + stat_width'(1);
    end
  end

  // ------------------------------------------------------------
  // error responses
  // ------------------------------------------------------------

  // for writes err comes from B, so it is not tied to the beat strobe
  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      err_cnt <= '0;
    end else if (err) begin
      err_cnt <= err_cnt + stat_width'(1);
    end
  end

endmodule

// File: logic/stat_regs.sv
`timescale 1ns/1ps

module stat_regs
  import axi_bus_pkg::*;
  import stat_map_pkg::*;
#(
  parameter int stat_width = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  rd,
  input  logic [reg_addr_w-1:0] addr,
  input  logic [stat_width-1:0] aw_burst_cnt,
  input  logic [depth_w-1:0]    aw_depth_max,
  input  logic [axi_len_w-1:0]  aw_len_min,
  input  logic [axi_len_w-1:0]  aw_len_max,
  input  logic [stat_width-1:0] aw_bytes_sum,
  input  logic [stat_width-1:0] w_burst_cnt,
  input  logic [depth_w-1:0]    w_depth_max,
  input  logic [stat_width-1:0] w_beat_cnt,
  input  logic [stat_width-1:0] w_err_cnt,
  input  logic [stat_width-1:0] ar_burst_cnt,
  input  logic [depth_w-1:0]    ar_depth_max,
  input  logic [axi_len_w-1:0]  ar_len_min,
  input  logic [axi_len_w-1:0]  ar_len_max,
  input  logic [stat_width-1:0] ar_bytes_sum,
  input  logic [stat_width-1:0] r_burst_cnt,
  input  logic [stat_width-1:0] r_beat_cnt,
  input  logic [stat_width-1:0] r_err_cnt,
  output logic [stat_width-1:0] rdata,
  output logic                  rvalid
);

  logic [stat_width-1:0] stat_sel;

  // unmapped addresses read as zero
  always_comb begin
    stat_sel = '0;
    if (int'(addr) < num_stats) begin
      case (stat_id_t'(addr))
        stat_aw_burst_cnt: stat_sel = aw_burst_cnt;
        stat_aw_depth_max: stat_sel = stat_width'(aw_depth_max);
        stat_aw_len_min:   stat_sel = stat_width'(aw_len_min);
        stat_aw_len_max:   stat_sel = stat_width'(aw_len_max);
        stat_aw_bytes_sum: stat_sel = aw_bytes_sum;
        stat_w_burst_cnt:  stat_sel = w_burst_cnt;
        stat_w_depth_max:  stat_sel = stat_width'(w_depth_max);
        stat_w_beat_cnt:   stat_sel = w_beat_cnt;
        stat_w_err_cnt:    stat_sel = w_err_cnt;
        stat_ar_burst_cnt: stat_sel = ar_burst_cnt;
        stat_ar_depth_max: stat_sel = stat_width'(ar_depth_max);
        stat_ar_len_min:   stat_sel = stat_width'(ar_len_min);
        stat_ar_len_max:   stat_sel = stat_width'(ar_len_max);
        stat_ar_bytes_sum: stat_sel = ar_bytes_sum;
        stat_r_burst_cnt:  stat_sel = r_burst_cnt;
        stat_r_beat_cnt:   stat_sel = r_beat_cnt;
        stat_r_err_cnt:    stat_sel = r_err_cnt;
        default:           stat_sel = '0;
      endcase
    end
  end

  // one read per cycle, answered exactly one cycle later
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else begin
      rvalid <= rd;
    end
  end

  always_ff @(posedge clk) begin
    if (rd) begin
      rdata <= stat_sel;
    end
  end

endmodule

// File: logic/axi_stats.sv
`timescale 1ns/1ps

module axi_stats
  import axi_bus_pkg::*;
  import stat_map_pkg::*;
#(
  parameter int stat_width = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  stat_clear,

  input  logic                  reg_rd,
  input  logic [reg_addr_w-1:0] reg_addr,
  output logic [stat_width-1:0] reg_rdata,
  output logic                  reg_rvalid,

  input  logic                  awvalid,
  input  logic                  awready,
  input  logic [axi_len_w-1:0]  awlen,
  input  logic [axi_size_w-1:0] awsize,

  input  logic                  wvalid,
  input  logic                  wready,
  input  logic                  wlast,

  input  logic                  bvalid,
  input  logic                  bready,
  input  axi_resp_t             bresp,

  input  logic                  arvalid,
  input  logic                  arready,
  input  logic [axi_len_w-1:0]  arlen,
  input  logic [axi_size_w-1:0] arsize,

  input  logic                  rvalid,
  input  logic                  rready,
  input  logic                  rlast,
  input  axi_resp_t             rresp
);

  logic aw_fire;
  logic w_fire;
  logic b_fire;
  logic ar_fire;
  logic r_fire;
  logic w_last_fire;
  logic r_last_fire;
  logic b_err;
  logic r_err;

  logic [stat_width-1:0] aw_burst_cnt;
  logic [stat_width-1:0] aw_bytes_sum;
  logic [axi_len_w-1:0]  aw_len_min;
  logic [axi_len_w-1:0]  aw_len_max;
  logic [stat_width-1:0] ar_burst_cnt;
  logic [stat_width-1:0] ar_bytes_sum;
  logic [axi_len_w-1:0]  ar_len_min;
  logic [axi_len_w-1:0]  ar_len_max;

  logic [depth_w-1:0] aw_depth;
  logic [depth_w-1:0] aw_depth_max;
  logic [depth_w-1:0] w_depth;
  logic [depth_w-1:0] w_depth_max;
  logic [depth_w-1:0] rd_depth;
  logic [depth_w-1:0] ar_depth_max;

  logic [stat_width-1:0] w_beat_cnt;
  logic [stat_width-1:0] w_burst_cnt;
  logic [stat_width-1:0] w_err_cnt;
  logic [stat_width-1:0] r_beat_cnt;
  logic [stat_width-1:0] r_burst_cnt;
  logic [stat_width-1:0] r_err_cnt;

  // ------------------------------------------------------------
  // handshake strobes
  // ------------------------------------------------------------

  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;
  assign b_fire  = bvalid && bready;
  assign ar_fire = arvalid && arready;
  assign r_fire  = rvalid && rready;

  assign w_last_fire = w_fire && wlast;
  assign r_last_fire = r_fire && rlast;

  // exokay also counts as an error here
  assign b_err = b_fire && (bresp != resp_okay);
  assign r_err = r_fire && (rresp != resp_okay);

  // ------------------------------------------------------------
  // address channel statistics
  // ------------------------------------------------------------

  burst_stats #(
    .stat_width (stat_width)
  ) aw_stats (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (stat_clear),
    .fire      (aw_fire),
    .len       (awlen),
    .size      (awsize),
    .burst_cnt (aw_burst_cnt),
    .bytes_sum (aw_bytes_sum),
    .len_min   (aw_len_min),
    .len_max   (aw_len_max)
  );

  burst_stats #(
    .stat_width (stat_width)
  ) ar_stats (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (stat_clear),
    .fire      (ar_fire),
    .len       (arlen),
    .size      (arsize),
    .burst_cnt (ar_burst_cnt),
    .bytes_sum (ar_bytes_sum),
    .len_min   (ar_len_min),
    .len_max   (ar_len_max)
  );

  // ------------------------------------------------------------
  // outstanding bursts
  // ------------------------------------------------------------

  // write address accepted until its B response
  depth_tracker aw_depth_trk (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (stat_clear),
    .inc       (aw_fire),
    .dec       (b_fire),
    .depth     (aw_depth),
    .depth_max (aw_depth_max)
  );

  // last write beat accepted until its B response
  depth_tracker w_depth_trk (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (stat_clear),
    .inc       (w_last_fire),
    .dec       (b_fire),
    .depth     (w_depth),
    .depth_max (w_depth_max)
  );

  // read address accepted until its last R beat
  depth_tracker rd_depth_trk (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (stat_clear),
    .inc       (ar_fire),
    .dec       (r_last_fire),
    .depth     (rd_depth),
    .depth_max (ar_depth_max)
  );

  // ------------------------------------------------------------
  // data channel statistics
  // ------------------------------------------------------------

  xfer_stats #(
    .stat_width (stat_width)
  ) w_stats (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (stat_clear),
    .beat      (w_fire),
    .last      (wlast),
    .err       (b_err),
    .beat_cnt  (w_beat_cnt),
    .burst_cnt (w_burst_cnt),
    .err_cnt   (w_err_cnt)
  );

  xfer_stats #(
    .stat_width (stat_width)
  ) r_stats (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (stat_clear),
    .beat      (r_fire),
    .last      (rlast),
    .err       (r_err),
    .beat_cnt  (r_beat_cnt),
    .burst_cnt (r_burst_cnt),
    .err_cnt   (r_err_cnt)
  );

  // ------------------------------------------------------------
  // register read port
  // ------------------------------------------------------------

  stat_regs #(
    .stat_width (stat_width)
  ) regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .rd           (reg_rd),
    .addr         (reg_addr),
    .aw_burst_cnt (aw_burst_cnt),
    .aw_depth_max (aw_depth_max),
    .aw_len_min   (aw_len_min),
    .aw_len_max   (aw_len_max),
    .aw_bytes_sum (aw_bytes_sum),
    .w_burst_cnt  (w_burst_cnt),
    .w_depth_max  (w_depth_max),
    .w_beat_cnt   (w_beat_cnt),
    .w_err_cnt    (w_err_cnt),
    .ar_burst_cnt (ar_burst_cnt),
    .ar_depth_max (ar_depth_max),
    .ar_len_min   (ar_len_min),
    .ar_len_max   (ar_len_max),
    .ar_bytes_sum (ar_bytes_sum),
    .r_burst_cnt  (r_burst_cnt),
    .r_beat_cnt   (r_beat_cnt),
    .r_err_cnt    (r_err_cnt),
    .rdata        (reg_rdata),
    .rvalid       (reg_rvalid)
  );

endmodule

// File: verification/axi_stats_asserts.sv
`timescale 1ns/1ps

module axi_stats_asserts
  import stat_map_pkg::*;
#(
  parameter int stat_width = 32
) (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  stat_clear,
  input logic                  reg_rd,
  input logic                  reg_rvalid,
  input logic                  aw_fire,
  input logic                  b_fire,
  input logic                  ar_fire,
  input logic                  w_last_fire,
  input logic                  r_last_fire,
  input logic [depth_w-1:0]    aw_depth,
  input logic [depth_w-1:0]    w_depth,
  input logic [depth_w-1:0]    rd_depth,
  input logic [stat_width-1:0] aw_burst_cnt,
  input logic [stat_width-1:0] ar_burst_cnt
);

  // ------------------------------------------------------------
  // register read port
  // ------------------------------------------------------------

  a_rvalid_follows_rd: assert property (@(posedge clk) disable iff (!rst_n)
    reg_rd |=> reg_rvalid)
    else $error("reg_rvalid missing one cycle after reg_rd");

  a_rvalid_only_after_rd: assert property (@(posedge clk) disable iff (!rst_n)
    !reg_rd |=> !reg_rvalid)
    else $error("reg_rvalid raised without a preceding reg_rd");

  // ------------------------------------------------------------
  // outstanding counters
  // ------------------------------------------------------------

  // a completion with no accept in the same cycle needs something outstanding
  a_aw_no_underflow: assert property (@(posedge clk) disable iff (!rst_n || stat_clear)
    (b_fire && !aw_fire) |-> (aw_depth != '0))
    else $error("AW outstanding count decremented at zero");

  a_w_no_underflow: assert property (@(posedge clk) disable iff (!rst_n || stat_clear)
    (b_fire && !w_last_fire) |-> (w_depth != '0))
    else $error("W outstanding count decremented at zero");

  a_rd_no_underflow: assert property (@(posedge clk) disable iff (!rst_n || stat_clear)
    (r_last_fire && !ar_fire) |-> (rd_depth != '0))
    else $error("read outstanding count decremented at zero");

  a_clear_zeroes: assert property (@(posedge clk) disable iff (!rst_n)
    stat_clear |=> ((aw_burst_cnt == '0) && (ar_burst_cnt == '0)))
    else $error("burst count not zero after stat_clear");

endmodule

bind axi_stats axi_stats_asserts #(
  .stat_width (stat_width)
) asserts0 (
  .clk          (clk),
  .rst_n        (rst_n),
  .stat_clear   (stat_clear),
  .reg_rd       (reg_rd),
  .reg_rvalid   (reg_rvalid),
  .aw_fire      (aw_fire),
  .b_fire       (b_fire),
  .ar_fire      (ar_fire),
  .w_last_fire  (w_last_fire),
  .r_last_fire  (r_last_fire),
  .aw_depth     (aw_depth),
  .w_depth      (w_depth),
  .rd_depth     (rd_depth),
  .aw_burst_cnt (aw_burst_cnt),
  .ar_burst_cnt (ar_burst_cnt)
);

// File: verification/axi_stats_tb.sv
`timescale 1ns/1ps

module axi_stats_tb
  import axi_bus_pkg::*;
  import stat_map_pkg::*;
();

  localparam int stat_width = 32;
  localparam int phase_cycles = 300;
  localparam int drain_cycles = 128;
  localparam int read_cycles = 4 * (num_stats + 1) + 2 * (2**reg_addr_w - num_stats);
  localparam int timeout_cycles = 2 * (2 * (phase_cycles + drain_cycles) + read_cycles + 32);

  logic                  clk;
  logic                  rst_n;
  logic                  stat_clear;
  logic                  reg_rd;
  logic [reg_addr_w-1:0] reg_addr;
  logic [stat_width-1:0] reg_rdata;
  logic                  reg_rvalid;
  logic                  awvalid;
  logic                  awready;
  logic [axi_len_w-1:0]  awlen;
  logic [axi_size_w-1:0] awsize;
  logic                  wvalid;
  logic                  wready;
  logic                  wlast;
  logic                  bvalid;
  logic                  bready;
  axi_resp_t             bresp;
  logic                  arvalid;
  logic                  arready;
  logic [axi_len_w-1:0]  arlen;
  logic [axi_size_w-1:0] arsize;
  logic                  rvalid;
  logic                  rready;
  logic                  rlast;
  axi_resp_t             rresp;

  // reference model state, updated from the strobes the testbench drives
  logic [stat_width-1:0] m_aw_cnt;
  logic [stat_width-1:0] m_aw_bytes;
  logic [axi_len_w-1:0]  m_aw_min;
  logic [axi_len_w-1:0]  m_aw_max;
  logic [stat_width-1:0] m_ar_cnt;
  logic [stat_width-1:0] m_ar_bytes;
  logic [axi_len_w-1:0]  m_ar_min;
  logic [axi_len_w-1:0]  m_ar_max;
  logic [stat_width-1:0] m_w_beats;
  logic [stat_width-1:0] m_w_bursts;
  logic [stat_width-1:0] m_w_errs;
  logic [stat_width-1:0] m_r_beats;
  logic [stat_width-1:0] m_r_bursts;
  logic [stat_width-1:0] m_r_errs;
  int                    aw_out;
  int                    w_out;
  int                    rd_out;
  int                    aw_peak;
  int                    w_peak;
  int                    rd_peak;

  logic                  rd_expect;
  logic                  check_on;
  int                    cycle_cnt;

  axi_stats #(
    .stat_width (stat_width)
  ) dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .stat_clear (stat_clear),
    .reg_rd     (reg_rd),
    .reg_addr   (reg_addr),
    .reg_rdata  (reg_rdata),
    .reg_rvalid (reg_rvalid),
    .awvalid    (awvalid),
    .awready    (awready),
    .awlen      (awlen),
    .awsize     (awsize),
    .wvalid     (wvalid),
    .wready     (wready),
    .wlast      (wlast),
    .bvalid     (bvalid),
    .bready     (bready),
    .bresp      (bresp),
    .arvalid    (arvalid),
    .arready    (arready),
    .arlen      (arlen),
    .arsize     (arsize),
    .rvalid     (rvalid),
    .rready     (rready),
    .rlast      (rlast),
    .rresp      (rresp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------

  task automatic check_stat(input stat_id_t id, input logic [stat_width-1:0] got,
                            input logic [stat_width-1:0] exp);
    if (got !== exp) begin
      $display("FAIL at %0t: %s read 0x%0h, expected 0x%0h", $time, id.name(), got, exp);
      $display("Test failures found");
      $fatal(1, "statistic register mismatch");
    end
  endtask

  task automatic check_valid(input logic exp, input logic got);
    if (got !== exp) begin
      $display("FAIL at %0t: reg_rvalid is %b, expected %b", $time, got, exp);
      $display("Test failures found");
      $fatal(1, "read response timing mismatch");
    end
  endtask

  task automatic check_unmapped(input logic [reg_addr_w-1:0] addr,
                                input logic [stat_width-1:0] got);
    if (got !== '0) begin
      $display("FAIL at %0t: reg_rdata at address %0d is 0x%0h, expected 0x0",
               $time, addr, got);
      $display("Test failures found");
      $fatal(1, "unmapped register mismatch");
    end
  endtask

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------

  task automatic reset_model();
    m_aw_cnt = '0;
    m_aw_bytes = '0;
    m_aw_min = '1;
    m_aw_max = '0;
    m_ar_cnt = '0;
    m_ar_bytes = '0;
    m_ar_min = '1;
    m_ar_max = '0;
    m_w_beats = '0;
    m_w_bursts = '0;
    m_w_errs = '0;
    m_r_beats = '0;
    m_r_bursts = '0;
    m_r_errs = '0;
    aw_out = 0;
    w_out = 0;
    rd_out = 0;
    aw_peak = 0;
    w_peak = 0;
    rd_peak = 0;
  endtask

  // a burst of len+1 beats of 2**size bytes each
  task automatic note_burst(inout logic [stat_width-1:0] cnt,
                            inout logic [stat_width-1:0] bytes,
                            inout logic [axi_len_w-1:0] len_lo,
                            inout logic [axi_len_w-1:0] len_hi,
                            input logic [axi_len_w-1:0] len,
                            input logic [axi_size_w-1:0] size);
    cnt = cnt + stat_width'(1);
    bytes = bytes + (stat_width'(len) + stat_width'(1)) * (stat_width'(1) << size);
    if (len < len_lo) len_lo = len;
    if (len > len_hi) len_hi = len;
  endtask

  function automatic logic [stat_width-1:0] model_stat(input stat_id_t id);
    case (id)
      stat_aw_burst_cnt: return m_aw_cnt;
      stat_aw_depth_max: return stat_width'(aw_peak);
      stat_aw_len_min:   return stat_width'(m_aw_min);
      stat_aw_len_max:   return stat_width'(m_aw_max);
      stat_aw_bytes_sum: return m_aw_bytes;
      stat_w_burst_cnt:  return m_w_bursts;
      stat_w_depth_max:  return stat_width'(w_peak);
      stat_w_beat_cnt:   return m_w_beats;
      stat_w_err_cnt:    return m_w_errs;
      stat_ar_burst_cnt: return m_ar_cnt;
      stat_ar_depth_max: return stat_width'(rd_peak);
      stat_ar_len_min:   return stat_width'(m_ar_min);
      stat_ar_len_max:   return stat_width'(m_ar_max);
      stat_ar_bytes_sum: return m_ar_bytes;
      stat_r_burst_cnt:  return m_r_bursts;
      stat_r_beat_cnt:   return m_r_beats;
      stat_r_err_cnt:    return m_r_errs;
      default:           return '0;
    endcase
  endfunction

  // ------------------------------------------------------------
  // bus stimulus
  // ------------------------------------------------------------

  function automatic logic one_in(input int unsigned n);
    return ($urandom_range(n - 1) == 0);
  endfunction

  function automatic axi_resp_t pick_resp();
    if (one_in(4)) begin
      return axi_resp_t'(2'($urandom_range(3)));
    end else begin
      return resp_okay;
    end
  endfunction

  // one clock of bus levels, recorded in the model as it is driven
  task automatic drive_bus(input logic awv, input logic awr,
                           input logic [axi_len_w-1:0] awl, input logic [axi_size_w-1:0] aws,
                           input logic wv, input logic wr, input logic wl,
                           input logic bv, input logic br, input axi_resp_t bres,
                           input logic arv, input logic arr,
                           input logic [axi_len_w-1:0] arl, input logic [axi_size_w-1:0] ars,
                           input logic rv, input logic rr, input logic rl,
                           input axi_resp_t rres);
    logic aw_f;
    logic w_f;
    logic b_f;
    logic ar_f;
    logic r_f;
    @(posedge clk);
    awvalid <= awv;
    awready <= awr;
    awlen <= awl;
    awsize <= aws;
    wvalid <= wv;
    wready <= wr;
    wlast <= wl;
    bvalid <= bv;
    bready <= br;
    bresp <= bres;
    arvalid <= arv;
    arready <= arr;
    arlen <= arl;
    arsize <= ars;
    rvalid <= rv;
    rready <= rr;
    rlast <= rl;
    rresp <= rres;
    aw_f = awv && awr;
    w_f = wv && wr;
    b_f = bv && br;
    ar_f = arv && arr;
    r_f = rv && rr;
    if (aw_f) note_burst(m_aw_cnt, m_aw_bytes, m_aw_min, m_aw_max, awl, aws);
    if (ar_f) note_burst(m_ar_cnt, m_ar_bytes, m_ar_min, m_ar_max, arl, ars);
    if (w_f) m_w_beats = m_w_beats + stat_width'(1);
    if (w_f && wl) m_w_bursts = m_w_bursts + stat_width'(1);
    if (b_f && (bres != resp_okay)) m_w_errs = m_w_errs + stat_width'(1);
    if (r_f) m_r_beats = m_r_beats + stat_width'(1);
    if (r_f && rl) m_r_bursts = m_r_bursts + stat_width'(1);
    if (r_f && (rres != resp_okay)) m_r_errs = m_r_errs + stat_width'(1);
    aw_out = aw_out + int'(aw_f) - int'(b_f);
    w_out = w_out + int'(w_f && wl) - int'(b_f);
    rd_out = rd_out + int'(ar_f) - int'(r_f && rl);
    if (aw_out > aw_peak) aw_peak = aw_out;
    if (w_out > w_peak) w_peak = w_out;
    if (rd_out > rd_peak) rd_peak = rd_out;
  endtask

  task automatic idle_bus(input int n);
    repeat (n) begin
      drive_bus(1'b0, 1'b0, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, resp_okay,
                1'b0, 1'b0, '0, '0, 1'b0, 1'b0, 1'b0, resp_okay);
    end
  endtask

  // B and last R beats are only offered while something is outstanding
  task automatic random_cycle(input logic wr_on, input logic rd_on);
    logic b_ok;
    logic r_ok;
    b_ok = (aw_out > 0) && (w_out > 0);
    r_ok = rd_out > 0;
    drive_bus(wr_on && one_in(2), one_in(2),
              axi_len_w'($urandom_range(255)), axi_size_w'($urandom_range(7)),
              wr_on && !one_in(4), !one_in(4), one_in(2),
              wr_on && b_ok && !one_in(4), !one_in(3), pick_resp(),
              rd_on && one_in(2), one_in(2),
              axi_len_w'($urandom_range(255)), axi_size_w'($urandom_range(7)),
              rd_on && !one_in(4), !one_in(4), r_ok && one_in(2), pick_resp());
  endtask

  // adds whichever side lags, so AW and W meet before B retires them
  task automatic drain_bus();
    while ((aw_out > 0) || (w_out > 0) || (rd_out > 0)) begin
      drive_bus(aw_out < w_out, 1'b1, '0, 3'd2,
                w_out < aw_out, 1'b1, 1'b1,
                (aw_out > 0) && (w_out > 0), 1'b1, resp_okay,
                1'b0, 1'b0, '0, '0,
                rd_out > 0, 1'b1, 1'b1, resp_slverr);
    end
  endtask

  // ------------------------------------------------------------
  // register readback
  // ------------------------------------------------------------

  // back-to-back reads of the whole map, each answer checked a cycle later
  task automatic check_all_regs();
    stat_id_t id;
    for (int i = 0; i <= num_stats; i++) begin
      @(posedge clk);
      reg_rd <= (i < num_stats);
      reg_addr <= reg_addr_w'(i);
      @(negedge clk);
      if (i > 0) begin
        id = stat_id_t'(reg_addr_w'(i - 1));
        check_valid(1'b1, reg_rvalid);
        check_stat(id, reg_rdata, model_stat(id));
      end
    end
  endtask

  task automatic read_one(input logic [reg_addr_w-1:0] addr,
                          output logic [stat_width-1:0] data);
    @(posedge clk);
    reg_rd <= 1'b1;
    reg_addr <= addr;
    @(posedge clk);
    reg_rd <= 1'b0;
    @(negedge clk);
    check_valid(1'b1, reg_rvalid);
    data = reg_rdata;
  endtask

  // reg_rvalid must mirror reg_rd from the previous edge in every cycle
  always @(posedge clk) begin
    rd_expect <= rst_n && reg_rd;
  end

  always @(negedge clk) begin
    if (check_on) check_valid(rd_expect, reg_rvalid);
  end

  initial begin : watchdog
    cycle_cnt = 0;
    forever begin
      @(posedge clk);
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= timeout_cycles) begin
        $display("ERROR: the run did not finish within %0d cycles", timeout_cycles);
        $display("Test failures found");
        $fatal(1, "timeout");
      end
    end
  end

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------

  initial begin : stimulus
    logic [stat_width-1:0] data;
    void'($urandom(32'h8a83));
    check_on = 1'b0;
    rst_n = 1'b0;
    stat_clear = 1'b0;
    reg_rd = 1'b0;
    reg_addr = '0;
    awvalid = 1'b0;
    awready = 1'b0;
    awlen = '0;
    awsize = '0;
    wvalid = 1'b0;
    wready = 1'b0;
    wlast = 1'b0;
    bvalid = 1'b0;
    bready = 1'b0;
    bresp = resp_okay;
    arvalid = 1'b0;
    arready = 1'b0;
    arlen = '0;
    arsize = '0;
    rvalid = 1'b0;
    rready = 1'b0;
    rlast = 1'b0;
    rresp = resp_okay;
    reset_model();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_on = 1'b1;

    check_all_regs();

    // write channels only
    repeat (phase_cycles) random_cycle(1'b1, 1'b0);
    drain_bus();
    idle_bus(4);
    check_all_regs();

    // all five channels at once
    repeat (phase_cycles) random_cycle(1'b1, 1'b1);
    drain_bus();
    idle_bus(4);
    check_all_regs();

    // unmapped addresses, read while the statistics still hold traffic
    for (int a = num_stats; a < 2**reg_addr_w; a++) begin
      read_one(reg_addr_w'(a), data);
      check_unmapped(reg_addr_w'(a), data);
    end

    @(posedge clk);
    stat_clear <= 1'b1;
    @(posedge clk);
    stat_clear <= 1'b0;
    reset_model();
    idle_bus(3);
    check_all_regs();

    $display("All tests passed!");
    $finish;
  end

endmodule

// File: vlog.f
logic/axi_bus_pkg.sv
logic/stat_map_pkg.sv
logic/burst_stats.sv
logic/depth_tracker.sv
logic/xfer_stats.sv
logic/stat_regs.sv
logic/axi_stats.sv
verification/axi_stats_asserts.sv
verification/axi_stats_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the axi_stats testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log_file=sim.log
rm -rf obj_dir "$log_file"

verilator --binary --timing --assert --top-module axi_stats_tb \
    -f vlog.f -o axi_stats_sim \
  && ./obj_dir/axi_stats_sim > "$log_file" 2>&1 \
  || echo "build or simulation ended with an error"

[ -f "$log_file" ] && cat "$log_file"

grep -q "All tests passed!" "$log_file" 2>/dev/null \
  && { echo "simulation PASSED"; exit 0; } \
  || { echo "simulation FAILED"; exit 1; }
